//--- verilog/macPkg.sv
// MAC shared definitions

package macPkg;

  // Operand and accumulator widths.
  typedef logic [15:0] operandT;     // an X or Y operand, and the MR0 part.
  typedef logic [39:0] accT;         // full accumulator and result value.
  typedef logic [7:0]  mr2T;         // guard bits above MR1.
  typedef logic [15:0] mr1T;         // upper word of the product area.

  // Operation codes.
  typedef logic [1:0] opcodeT;

  localparam opcodeT OpMul  = 2'd0;  // mr becomes x*y.
  localparam opcodeT OpMac  = 2'd1;  // mr becomes mr + x*y.
  localparam opcodeT OpMsub = 2'd2;  // mr becomes mr - x*y.
  // Code 3 is unassigned and decodes like a plain multiply.

  // Flow control.
  typedef logic [2:0] creditCntT;    // holds credit limits up to 7.

  // Bit where the rounding one goes in, counted on the final result.
  localparam int RoundBit = 15;

endpackage

//--- verilog/boothRow.sv
// Booth partial product row
`timescale 1ns/100ps

module boothRow (
  input  macPkg::operandT x,
  input  logic            xUnsigned,
  input  logic [2:0]      digit,
  input  logic            negate,
  output logic [17:0]     row,
  output logic            carryIn
);

  logic        xSign;
  logic [17:0] xOne;
  logic [17:0] xTwo;
  logic [17:0] mag;
  logic        onePos;
  logic        twoPos;
  logic        oneNeg;
  logic        twoNeg;
  logic        plusOne;
  logic        plusTwo;
  logic        minusOne;
  logic        minusTwo;

  assign xSign = ~xUnsigned & x[15];    // an unsigned x never extends a one.
  assign xOne  = {xSign, xSign, x};
  assign xTwo  = {xSign, x, 1'b0};

  // Radix-4 recoding of the overlapping triplet.
  always_comb begin
    {onePos, twoPos, oneNeg, twoNeg} = 4'b0000;
    case (digit)
      3'b001, 3'b010: onePos = 1'b1;
      3'b011:         twoPos = 1'b1;
      3'b100:         twoNeg = 1'b1;
      3'b101, 3'b110: oneNeg = 1'b1;
      default:        {onePos, twoPos, oneNeg, twoNeg} = 4'b0000;
    endcase
  end

  // A subtract flips the sign of every digit.
  assign plusOne  = negate ? oneNeg : onePos;
  assign plusTwo  = negate ? twoNeg : twoPos;
  assign minusOne = negate ? onePos : oneNeg;
  assign minusTwo = negate ? twoPos : twoNeg;

  assign mag = ({18{plusOne | minusOne}} & xOne) | ({18{plusTwo | minusTwo}} & xTwo);

  // Negative rows leave as the one's complement, the +1 is added in the tree.
  assign carryIn = minusOne | minusTwo;
  assign row     = carryIn ? ~mag : mag;

endmodule

//--- verilog/macCore.sv
// Booth MAC datapath
`timescale 1ns/100ps

module macCore (
  input  macPkg::operandT x,
  input  macPkg::operandT y,
  input  logic            xUnsigned,
  input  logic            yUnsigned,
  input  logic            fracMode,
  input  logic            round,
  input  logic            subtract,
  input  logic            mzero,
  input  logic            biasRound,
  input  macPkg::accT     accIn,
  output macPkg::accT     macOut
);
  import macPkg::*;

  localparam int NumRows  = 8;
  localparam int NumTerms = 12;
  localparam int AccW     = $bits(accT);

  logic [17:0]        rows [NumRows];
  logic [NumRows-1:0] rowCarry;
  logic [16:0]        yExt;
  logic [16:0]        xExt;
  logic               corrSel;
  logic [16:0]        corrRow;
  accT                terms [NumTerms];
  accT                accFeed;
  accT                accTerm;
  accT                rndTerm;
  accT                cinTerm;
  accT                lvl1 [8];
  accT                lvl2 [4];
  accT                sumVec;
  accT                carryVec;
  accT                gLvl [7];
  accT                pLvl [6];
  accT                rawSum;
  accT                shifted;
  logic               lowZero;
  logic               bit16;

  // 3:2 counter on whole vectors, returns {carry, sum}.
  function automatic logic [2*AccW-1:0] csa32(accT a, accT b, accT c);
    accT s;
    accT cy;
    s  = a ^ b ^ c;
    cy = ((a & b) | (b & c) | (c & a)) << 1;
    return {cy, s};
  endfunction

  // 4:2 compressor built from two chained counters.
  function automatic logic [2*AccW-1:0] csa42(accT a, accT b, accT c, accT d);
    logic [2*AccW-1:0] first;
    logic [2*AccW-1:0] second;
    first  = csa32(a, b, c);
    second = csa32(first[AccW-1:0], first[2*AccW-1:AccW], d);
    return second;
  endfunction

  assign yExt = {y, 1'b0};

  for (genvar i = 0; i < NumRows; i++) begin : gRow
    boothRow uRow (
      .x         (x),
      .xUnsigned (xUnsigned),
      .digit     (yExt[2*i+2 -: 3]),
      .negate    (subtract),
      .row       (rows[i]),
      .carryIn   (rowCarry[i])
    );
    assign terms[i] = accT'($signed(rows[i])) << (2 * i);
  end

  // Booth treats y as signed, so an unsigned y with its top bit set needs x*2^16 more.
  assign xExt    = {~xUnsigned & x[15], x};
  assign corrSel = yUnsigned & y[15];
  assign corrRow = corrSel ? (subtract ? ~xExt : xExt) : '0;
  assign terms[8] = accT'($signed(corrRow)) << 16;

  always_comb begin
    cinTerm = '0;
    for (int i = 0; i < NumRows; i++) begin
      cinTerm[2*i] = rowCarry[i];
    end
    cinTerm[16] = corrSel & subtract;    // completes the negated correction row.
  end
  assign terms[9] = cinTerm;

  // In fractional mode mr enters halved, so the final left shift doubles only the product.
  assign accFeed  = mzero ? '0 : accIn;
  assign accTerm  = fracMode ? {accFeed[AccW-1], accFeed[AccW-1:1]} : accFeed;
  assign rndTerm  = round ? (accT'(1) << (fracMode ? RoundBit - 1 : RoundBit)) : '0;
  assign terms[10] = accTerm;
  assign terms[11] = rndTerm;

  for (genvar i = 0; i < 4; i++) begin : gLevel1
    assign {lvl1[2*i+1], lvl1[2*i]} = csa32(terms[3*i], terms[3*i+1], terms[3*i+2]);
  end

  for (genvar i = 0; i < 2; i++) begin : gLevel2
    assign {lvl2[2*i+1], lvl2[2*i]} = csa42(lvl1[4*i], lvl1[4*i+1], lvl1[4*i+2],
                                            lvl1[4*i+3]);
  end

  assign {carryVec, sumVec} = csa42(lvl2[0], lvl2[1], lvl2[2], lvl2[3]);

  // Kogge-Stone carry tree over the final pair.
  assign gLvl[0] = sumVec & carryVec;
  assign pLvl[0] = sumVec ^ carryVec;

  for (genvar k = 0; k < 6; k++) begin : gPrefix
    localparam int Dist = 1 << k;
    assign gLvl[k+1] = gLvl[k] | (pLvl[k] & (gLvl[k] << Dist));
    if (k < 5) begin : gProp
      assign pLvl[k+1] = pLvl[k] & (pLvl[k] << Dist);
    end
  end

  assign rawSum = pLvl[0] ^ (gLvl[6] << 1);

  assign shifted = fracMode ? {rawSum[AccW-2:0], accFeed[0]} : rawSum;

  // Unbiased mode rounds an exact half to even by dropping bit 16.
  assign lowZero = ~|shifted[RoundBit:0];
  assign bit16   = shifted[RoundBit+1] & ~(round & ~biasRound & lowZero);

  assign macOut = {shifted[AccW-1:RoundBit+2], bit16, shifted[RoundBit:0]};

endmodule

//--- verilog/macAccumRegs.sv
// MAC accumulator registers
`timescale 1ns/100ps

module macAccumRegs (
  input  logic           clk,
  input  logic           rst,
  input  logic           issue,
  input  macPkg::opcodeT headOp,
  input  macPkg::accT    macOut,
  output macPkg::accT    accIn,
  output logic           subtract,
  output logic           mzero,
  output macPkg::accT    resMr,
  output logic           resOverflow
);
  import macPkg::*;

  localparam int OvfLsb = 31;    // top of a 32-bit signed result.

  mr2T     mr2;
  mr1T     mr1;
  operandT mr0;
  accT     mrVal;
  logic    nextOverflow;

  always_comb begin
    case (headOp)
      OpMac: begin
        mzero    = 1'b0;
        subtract = 1'b0;
      end
      OpMsub: begin
        mzero    = 1'b0;
        subtract = 1'b1;
      end
      default: begin
        mzero    = 1'b1;         // plain multiply, the spare code included.
        subtract = 1'b0;
      end
    endcase
  end

  assign mrVal = {mr2, mr1, mr0};

  // mr feeds the core only while an operation issues.
  assign accIn = issue ? mrVal : '0;

  // set when the guard bits and bit 31 disagree.
  assign nextOverflow = ~((&macOut[$bits(accT)-1:OvfLsb]) | ~(|macOut[$bits(accT)-1:OvfLsb]));

  always_ff @(posedge clk) begin
    if (rst) begin
      mr2         <= '0;
      mr1         <= '0;
      mr0         <= '0;
      resOverflow <= 1'b0;
    end else if (issue) begin
      {mr2, mr1, mr0} <= macOut;
      resOverflow     <= nextOverflow;
    end
  end

  assign resMr = mrVal;

endmodule

//--- verilog/macFlowCtrl.sv
// MAC credit flow control
`timescale 1ns/100ps

module macFlowCtrl #(
  parameter int InDepth    = 2,
  parameter int OutCredits = 2
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            inValid,
  input  macPkg::operandT x,
  input  macPkg::operandT y,
  input  macPkg::opcodeT  opcode,
  input  logic            xUnsigned,
  input  logic            yUnsigned,
  input  logic            fracMode,
  input  logic            round,
  input  logic            resCredit,
  output macPkg::operandT headX,
  output macPkg::operandT headY,
  output macPkg::opcodeT  headOp,
  output logic            headXu,
  output logic            headYu,
  output logic            headFrac,
  output logic            headRnd,
  output logic            issue,
  output logic            inCredit,
  output logic            resValid
);
  import macPkg::*;

  localparam int EntryW = $bits(opcodeT) + 4 + 2 * $bits(operandT);
  localparam int PtrW   = (InDepth > 1) ? $clog2(InDepth) : 1;
  localparam int CntW   = $clog2(InDepth + 1);

  logic [EntryW-1:0] entries [InDepth];
  logic [PtrW-1:0]   wrPtr;
  logic [PtrW-1:0]   rdPtr;
  logic [CntW-1:0]   qCount;
  creditCntT         outCnt;
  logic              push;

  function automatic logic [PtrW-1:0] nextPtr(logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(InDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign push  = inValid && (qCount != CntW'(InDepth));    // a push into a full queue is dropped.
  assign issue = (qCount != '0) && (outCnt != '0);

  assign {headOp, headXu, headYu, headFrac, headRnd, headX, headY} = entries[rdPtr];

  always_ff @(posedge clk) begin
    if (push) begin
      entries[wrPtr] <= {opcode, xUnsigned, yUnsigned, fracMode, round, x, y};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wrPtr  <= '0;
      rdPtr  <= '0;
      qCount <= '0;
    end else begin
      if (push) wrPtr <= nextPtr(wrPtr);
      if (issue) rdPtr <= nextPtr(rdPtr);
      case ({push, issue})
        2'b10:   qCount <= qCount + 1'b1;
        2'b01:   qCount <= qCount - 1'b1;
        default: qCount <= qCount;
      endcase
    end
  end

  // each issue hands one input credit back and spends one output credit.
  always_ff @(posedge clk) begin
    if (rst) begin
      outCnt   <= creditCntT'(OutCredits);
      resValid <= 1'b0;
      inCredit <= 1'b0;
    end else begin
      resValid <= issue;
      inCredit <= issue;
      case ({issue, resCredit})
        2'b10:   outCnt <= outCnt - 1'b1;
        2'b01:   outCnt <= outCnt + 1'b1;
        default: outCnt <= outCnt;
      endcase
    end
  end

endmodule

//--- verilog/macUnit.sv
// MAC unit top level
`timescale 1ns/100ps

module macUnit #(
  parameter int InDepth    = 2,
  parameter int OutCredits = 2
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            inValid,
  input  macPkg::operandT x,
  input  macPkg::operandT y,
  input  macPkg::opcodeT  opcode,
  input  logic            xUnsigned,
  input  logic            yUnsigned,
  input  logic            fracMode,
  input  logic            round,
  input  logic            biasRound,
  input  logic            resCredit,
  output logic            inCredit,
  output logic            resValid,
  output macPkg::accT     resMr,
  output logic            resOverflow
);
  import macPkg::*;

  operandT headX;
  operandT headY;
  opcodeT  headOp;
  logic    headXu;
  logic    headYu;
  logic    headFrac;
  logic    headRnd;
  logic    issue;
  logic    subtract;
  logic    mzero;
  accT     accIn;
  accT     macOut;

  macFlowCtrl #(
    .InDepth    (InDepth),
    .OutCredits (OutCredits)
  ) uFlow (
    .clk       (clk),
    .rst       (rst),
    .inValid   (inValid),
    .x         (x),
    .y         (y),
    .opcode    (opcode),
    .xUnsigned (xUnsigned),
    .yUnsigned (yUnsigned),
    .fracMode  (fracMode),
    .round     (round),
    .resCredit (resCredit),
    .headX     (headX),
    .headY     (headY),
    .headOp    (headOp),
    .headXu    (headXu),
    .headYu    (headYu),
    .headFrac  (headFrac),
    .headRnd   (headRnd),
    .issue     (issue),
    .inCredit  (inCredit),
    .resValid  (resValid)
  );

  macAccumRegs uAccum (
    .clk         (clk),
    .rst         (rst),
    .issue       (issue),
    .headOp      (headOp),
    .macOut      (macOut),
    .accIn       (accIn),
    .subtract    (subtract),
    .mzero       (mzero),
    .resMr       (resMr),
    .resOverflow (resOverflow)
  );

  macCore uCore (
    .x         (headX),
    .y         (headY),
    .xUnsigned (headXu),
    .yUnsigned (headYu),
    .fracMode  (headFrac),
    .round     (headRnd),
    .subtract  (subtract),
    .mzero     (mzero),
    .biasRound (biasRound),
    .accIn     (accIn),
    .macOut    (macOut)
  );

endmodule

//--- sim/macUnit_sva.sv
// MAC flow control assertions
`timescale 1ns/100ps

module macUnit_sva #(
  parameter int InDepth    = 2,
  parameter int OutCredits = 2
) (
  input logic                         clk,
  input logic                         rst,
  input logic                         inValid,
  input logic                         issue,
  input logic [$clog2(InDepth+1)-1:0] qCount,
  input macPkg::creditCntT            outCnt,
  input logic [$bits(macPkg::opcodeT)+4+2*$bits(macPkg::operandT)-1:0] head
);

  noFullPush: assert property (@(posedge clk) disable iff (rst)
    !(inValid && qCount == InDepth))
    else $error("operand pushed into a full queue");

  creditBound: assert property (@(posedge clk) disable iff (rst) outCnt <= OutCredits)
    else $error("output credit count above its initial value");

  headHeld: assert property (@(posedge clk) disable iff (rst)
    qCount != 0 && !issue |=> $stable(head))
    else $error("queue head changed while it waited to issue");

endmodule

bind macFlowCtrl macUnit_sva #(
  .InDepth    (InDepth),
  .OutCredits (OutCredits)
) uSva (
  .clk     (clk),
  .rst     (rst),
  .inValid (inValid),
  .issue   (issue),
  .qCount  (qCount),
  .outCnt  (outCnt),
  .head    ({headOp, headXu, headYu, headFrac, headRnd, headX, headY})
);

//--- sim/macUnitTb.sv
// MAC unit testbench
`timescale 1ns/100ps

module macUnitTb;
  import macPkg::*;

  localparam int InDepth    = 2;
  localparam int OutCredits = 2;

  typedef struct packed {
    opcodeT  op;
    logic    xu;
    logic    yu;
    logic    frac;
    logic    rnd;
    operandT x;
    operandT y;
  } macOpT;

  logic    clk       = 1'b0;
  logic    rst       = 1'b1;
  logic    inValid   = 1'b0;
  operandT x         = '0;
  operandT y         = '0;
  opcodeT  opcode    = OpMul;
  logic    xUnsigned = 1'b0;
  logic    yUnsigned = 1'b0;
  logic    fracMode  = 1'b0;
  logic    round     = 1'b0;
  logic    biasRound = 1'b1;
  logic    resCredit = 1'b0;
  logic    inCredit;
  logic    resValid;
  accT     resMr;
  logic    resOverflow;

  macOpT  sendQ [$];    // operations not yet offered to the unit.
  macOpT  expQ [$];     // operations accepted and waiting for their result.
  accT    modelMr;
  integer seed          = 32'he72b;
  int     errors        = 0;
  int     credits       = 0;
  int     owed          = 0;
  int     sentCount     = 0;
  int     resultCount   = 0;
  int     inCreditCount = 0;
  logic   holdCredits   = 1'b0;
  logic   timedOut      = 1'b0;
  int     baseResults;
  int     baseSent;
  int     baseCredits;

  macUnit #(
    .InDepth    (InDepth),
    .OutCredits (OutCredits)
  ) UUT (
    .clk         (clk),
    .rst         (rst),
    .inValid     (inValid),
    .x           (x),
    .y           (y),
    .opcode      (opcode),
    .xUnsigned   (xUnsigned),
    .yUnsigned   (yUnsigned),
    .fracMode    (fracMode),
    .round       (round),
    .biasRound   (biasRound),
    .resCredit   (resCredit),
    .inCredit    (inCredit),
    .resValid    (resValid),
    .resMr       (resMr),
    .resOverflow (resOverflow)
  );

  always #50 clk = ~clk;

  // Next MR and overflow flag, returned as {overflow, mr}.
  function automatic logic [40:0] refMac(accT oldMr, macOpT op, logic bias);
    logic [63:0] xv;
    logic [63:0] yv;
    logic [63:0] prod;
    logic [63:0] total;
    accT         res;
    logic        ovf;
    xv   = op.xu ? {48'd0, op.x} : {{48{op.x[15]}}, op.x};
    yv   = op.yu ? {48'd0, op.y} : {{48{op.y[15]}}, op.y};
    prod = xv * yv;
    if (op.frac) prod = prod << 1;
    case (op.op)
      OpMac:   total = {24'd0, oldMr} + prod;
      OpMsub:  total = {24'd0, oldMr} - prod;
      default: total = prod;
    endcase
    if (op.rnd) total = total + (64'd1 << RoundBit);
    res = total[39:0];
    if (op.rnd && !bias && res[RoundBit:0] == '0) res[RoundBit+1] = 1'b0;    // ties go to even.
    ovf = (res[39:31] != 9'h000) && (res[39:31] != 9'h1ff);
    return {ovf, res};
  endfunction

  task automatic queueOp(input opcodeT op, input logic xu, input logic yu, input logic frac,
                         input logic rnd, input operandT xv, input operandT yv);
    sendQ.push_back({op, xu, yu, frac, rnd, xv, yv});
  endtask

  task automatic queueRandom(input int count, input logic mixOps, input logic frac,
                             input logic rnd, input opcodeT op);
    logic [31:0] r;
    logic [31:0] v;
    repeat (count) begin
      r = $random(seed);
      v = $random(seed);
      queueOp(mixOps ? r[5:4] : op, r[0], r[1], frac & r[2], rnd & r[3], v[15:0], v[31:16]);
    end
  endtask

  task automatic waitIdle(input int limit);
    int cycles;
    cycles = 0;
    while (!timedOut && !(sendQ.size() == 0 && expQ.size() == 0 && owed == 0 && !resCredit)) begin
      @(negedge clk);
      cycles++;
      if (cycles > limit) begin
        $display("Timeout at %0t: outstanding operations did not drain", $time);
        errors++;
        timedOut = 1'b1;
      end
    end
  endtask

  task automatic waitResults(input int target, input int limit);
    int cycles;
    cycles = 0;
    while (!timedOut && resultCount < target) begin
      @(negedge clk);
      cycles++;
      if (cycles > limit) begin
        $display("Timeout at %0t: expected results never arrived", $time);
        errors++;
        timedOut = 1'b1;
      end
    end
  endtask

  task automatic runRounding(input logic bias);
    logic [31:0] r;
    @(posedge clk);
    biasRound <= bias;
    queueOp(OpMul, 1'b0, 1'b0, 1'b1, 1'b1, 16'h4000, 16'h0001);
    queueOp(OpMul, 1'b0, 1'b0, 1'b1, 1'b1, 16'h4000, 16'h0003);
    queueOp(OpMul, 1'b0, 1'b0, 1'b1, 1'b1, 16'h4000, 16'h0005);
    queueOp(OpMul, 1'b0, 1'b0, 1'b1, 1'b1, 16'hc000, 16'h0001);
    queueOp(OpMul, 1'b0, 1'b0, 1'b0, 1'b1, 16'h0100, 16'h0080);
    queueOp(OpMac, 1'b0, 1'b0, 1'b1, 1'b1, 16'h4000, 16'h0001);
    queueOp(OpMsub, 1'b0, 1'b0, 1'b1, 1'b1, 16'h4000, 16'h0003);
    repeat (30) begin
      r = $random(seed);
      queueOp(r[1:0], 1'b0, r[2], 1'b1, 1'b1, {r[4:3], 14'd0}, {13'd0, r[7:5]});    // many ties.
    end
    queueRandom(30, 1'b1, 1'b1, 1'b1, OpMul);
    waitIdle(3000);
  endtask

  // Producer spends one input credit per operation.
  always @(posedge clk) begin : producer
    macOpT nextOp;
    if (rst) begin
      inValid <= 1'b0;
      credits = InDepth;
    end else begin
      if (inCredit) credits = credits + 1;
      if (credits > InDepth) begin
        $display("Error at %0t: more input credits returned than the queue holds", $time);
        errors++;
      end
      if (sendQ.size() > 0 && credits > 0 && ($random(seed) & 3) != 0) begin
        nextOp = sendQ.pop_front();
        inValid   <= 1'b1;
        opcode    <= nextOp.op;
        xUnsigned <= nextOp.xu;
        yUnsigned <= nextOp.yu;
        fracMode  <= nextOp.frac;
        round     <= nextOp.rnd;
        x         <= nextOp.x;
        y         <= nextOp.y;
        expQ.push_back(nextOp);
        credits = credits - 1;
        sentCount++;
      end else begin
        inValid <= 1'b0;
      end
    end
  end

  // Consumer hands result credits back at random.
  always @(posedge clk) begin : consumer
    if (rst) begin
      resCredit <= 1'b0;
      owed = 0;
    end else begin
      if (resValid) owed++;
      if (!holdCredits && owed > 0 && ($random(seed) & 1)) begin
        resCredit <= 1'b1;
        owed--;
      end else begin
        resCredit <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin : compare
    macOpT head;
    accT   expMr;
    logic  expOvf;
    if (rst) begin
      modelMr = '0;
    end else begin
      if (inCredit) inCreditCount++;
      if (resValid) begin
        resultCount++;
        if (expQ.size() == 0) begin
          $display("Error at %0t: a result appeared with no operation outstanding", $time);
          errors++;
        end else begin
          head = expQ.pop_front();
          {expOvf, expMr} = refMac(modelMr, head, biasRound);
          modelMr = expMr;
          if (resMr !== expMr) begin
            $display("Mismatch at %0t: resMr %h, expected %h", $time, resMr, expMr);
            errors++;
          end
          if (resOverflow !== expOvf) begin
            $display("Mismatch at %0t: resOverflow %b, expected %b", $time, resOverflow, expOvf);
            errors++;
          end
        end
      end
    end
  end

  initial begin : mainSeq
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    repeat (8) begin
      @(negedge clk);
      if (resValid || inCredit) begin
        $display("Error at %0t: resValid or inCredit rose before any operation", $time);
        errors++;
      end
    end

    // the first accumulate starts from a cleared MR.
    queueOp(OpMac, 1'b0, 1'b0, 1'b0, 1'b0, 16'd3, 16'hfffb);
    queueOp(OpMul, 1'b0, 1'b0, 1'b0, 1'b0, 16'h8000, 16'h8000);
    queueOp(OpMul, 1'b1, 1'b1, 1'b0, 1'b0, 16'hffff, 16'hffff);
    queueOp(OpMul, 1'b1, 1'b0, 1'b0, 1'b0, 16'hffff, 16'h8000);
    queueOp(OpMul, 1'b0, 1'b1, 1'b0, 1'b0, 16'h8000, 16'hffff);
    queueOp(OpMul, 1'b0, 1'b0, 1'b1, 1'b0, 16'h8000, 16'h8000);
    queueOp(2'd3, 1'b0, 1'b0, 1'b0, 1'b0, 16'h1234, 16'hfedc);
    queueRandom(40, 1'b0, 1'b0, 1'b0, OpMul);
    waitIdle(2000);

    // long chains run through the whole 40-bit range.
    queueOp(OpMul, 1'b0, 1'b0, 1'b0, 1'b0, 16'd0, 16'd0);
    repeat (130) queueOp(OpMac, 1'b1, 1'b1, 1'b1, 1'b0, 16'hffff, 16'hffff);
    repeat (130) queueOp(OpMsub, 1'b0, 1'b0, 1'b1, 1'b0, 16'h8000, 16'h8000);
    queueRandom(60, 1'b1, 1'b1, 1'b0, OpMac);
    waitIdle(20000);

    runRounding(1'b0);
    runRounding(1'b1);

    // Hold result credits back and watch the unit stall.
    baseResults = resultCount;
    baseSent    = sentCount;
    baseCredits = inCreditCount;
    @(posedge clk);
    holdCredits <= 1'b1;
    @(negedge clk);
    queueRandom(6, 1'b0, 1'b0, 1'b0, OpMac);
    waitResults(baseResults + OutCredits, 200);
    repeat (30) @(negedge clk);
    if (resultCount - baseResults != OutCredits || inCreditCount - baseCredits != OutCredits ||
        sentCount - baseSent != InDepth + OutCredits) begin
      $display("Mismatch at %0t: stalled unit passed %0d results, %0d credits, %0d operations",
               $time, resultCount - baseResults, inCreditCount - baseCredits,
               sentCount - baseSent);
      errors++;
    end
    @(posedge clk);
    holdCredits <= 1'b0;
    waitIdle(500);

    $display("Run complete: %0d results compared, %0d errors", resultCount, errors);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- flist.f
verilog/macPkg.sv
verilog/boothRow.sv
verilog/macCore.sv
verilog/macAccumRegs.sv
verilog/macFlowCtrl.sv
verilog/macUnit.sv
sim/macUnit_sva.sv
sim/macUnitTb.sv

//--- Bender.yml
package:
  name: mac_unit

sources:
  - verilog/macPkg.sv
  - verilog/boothRow.sv
  - verilog/macCore.sv
  - verilog/macAccumRegs.sv
  - verilog/macFlowCtrl.sv
  - verilog/macUnit.sv
  - target: simulation
    files:
      - sim/macUnit_sva.sv
      - sim/macUnitTb.sv
